/* Bender.yml */
package:
  name: bp_fe

sources:
  - rtl/bp_fe_cfg_pkg.sv
  - rtl/bp_fe_pkg.sv
  - rtl/bp_fe_bht.sv
  - rtl/bp_fe_btb.sv
  - rtl/bp_fe_branch_predictor.sv
  - rtl/bp_fe_pc_gen.sv
  - rtl/bp_fe_top.sv
  - target: test
    files:
      - verification/bp_fe_tb.sv

/* rtl/bp_fe_bht.sv */
`timescale 1ns/1ps

// branch history table of 2-bit saturating counters
module bp_fe_bht
  (input  logic                                     clk_i
   , input  logic                                   rst_n_i

   , input  logic                                   r_v_i
   , input  logic [bp_fe_cfg_pkg::bht_indx_width-1:0] idx_r_i

   , input  logic                                   w_v_i
   , input  logic [bp_fe_cfg_pkg::bht_indx_width-1:0] idx_w_i
   , input  logic                                   taken_i

   , output logic                                   predict_o
   );

   localparam int bht_entries = 1 << bp_fe_cfg_pkg::bht_indx_width;

   bp_fe_cfg_pkg::bp_fe_ctr_e ctr_q [bht_entries];
   bp_fe_cfg_pkg::bp_fe_ctr_e ctr_r_q;
   bp_fe_cfg_pkg::bp_fe_ctr_e ctr_next;

   // step the written counter one state toward the resolved direction
   always_comb begin
      ctr_next = ctr_q[idx_w_i];
      unique case (ctr_q[idx_w_i])
         bp_fe_cfg_pkg::e_strong_nt: ctr_next = taken_i ? bp_fe_cfg_pkg::e_weak_nt
                                                        : bp_fe_cfg_pkg::e_strong_nt;
         bp_fe_cfg_pkg::e_weak_nt:   ctr_next = taken_i ? bp_fe_cfg_pkg::e_weak_t
                                                        : bp_fe_cfg_pkg::e_strong_nt;
         bp_fe_cfg_pkg::e_weak_t:    ctr_next = taken_i ? bp_fe_cfg_pkg::e_strong_t
                                                        : bp_fe_cfg_pkg::e_weak_nt;
         bp_fe_cfg_pkg::e_strong_t:  ctr_next = taken_i ? bp_fe_cfg_pkg::e_strong_t
                                                        : bp_fe_cfg_pkg::e_weak_t;
         default:                    ctr_next = bp_fe_cfg_pkg::e_weak_nt;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < bht_entries; i++) begin
            ctr_q[i] <= bp_fe_cfg_pkg::e_weak_nt;
         end
      end else if (w_v_i) begin
         ctr_q[idx_w_i] <= ctr_next;
      end
   end

   // a write in the same cycle is not seen by this read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctr_r_q <= bp_fe_cfg_pkg::e_weak_nt;
      end else if (r_v_i) begin
         ctr_r_q <= ctr_q[idx_r_i];
      end
   end

   assign predict_o = (ctr_r_q == bp_fe_cfg_pkg::e_weak_t)
                      || (ctr_r_q == bp_fe_cfg_pkg::e_strong_t);

   // training index comes back from the back end through the metadata
   a_idx_w_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_v_i |-> !$isunknown(idx_w_i));

endmodule

/* rtl/bp_fe_branch_predictor.sv */
`timescale 1ns/1ps

// direction from the BHT and target from the BTB
module bp_fe_branch_predictor
  (input  logic                                  clk_i
   , input  logic                                rst_n_i

   , input  logic                                lookup_v_i
   , input  logic [bp_fe_cfg_pkg::eaddr_width-1:0] lookup_pc_i
   , input  bp_fe_pkg::bp_fe_cmd_s               cmd_i

   , output logic                                pred_taken_o
   , output logic [bp_fe_cfg_pkg::eaddr_width-1:0] pred_target_o
   , output bp_fe_pkg::bp_fe_branch_metadata_s   pred_metadata_o
   );

   bp_fe_pkg::bp_fe_branch_metadata_s lookup_md;
   bp_fe_pkg::bp_fe_branch_metadata_s lookup_md_q;

   logic bht_predict;
   logic btb_hit;
   logic bht_w_v;
   logic btb_w_v;

   // indices start above the byte offset and the tag sits above the BTB index
   assign lookup_md.btb_indx = lookup_pc_i[2 +: bp_fe_cfg_pkg::btb_indx_width];
   assign lookup_md.btb_tag  = lookup_pc_i[bp_fe_cfg_pkg::eaddr_width-1 -:
                                           bp_fe_cfg_pkg::btb_tag_width];
   assign lookup_md.bht_indx = lookup_pc_i[2 +: bp_fe_cfg_pkg::bht_indx_width];

   // delay the metadata by the same cycle as the table reads
   always_ff @(posedge clk_i) begin
      if (lookup_v_i) begin
         lookup_md_q <= lookup_md;
      end
   end

   always_comb begin
      bht_w_v = 1'b0;
      btb_w_v = 1'b0;
      if (cmd_i.v) begin
         unique case (cmd_i.op)
            bp_fe_pkg::e_op_attaboy:    bht_w_v = 1'b1;
            bp_fe_pkg::e_op_mispredict: begin
               bht_w_v = 1'b1;
               btb_w_v = cmd_i.taken;
            end
            default: ;
         endcase
      end
   end

   bp_fe_bht bht_i
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .r_v_i(lookup_v_i)
      , .idx_r_i(lookup_md.bht_indx)
      , .w_v_i(bht_w_v)
      , .idx_w_i(cmd_i.metadata.bht_indx)
      , .taken_i(cmd_i.taken)
      , .predict_o(bht_predict)
      );

   bp_fe_btb btb_i
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .r_v_i(lookup_v_i)
      , .idx_r_i(lookup_md.btb_indx)
      , .tag_r_i(lookup_md.btb_tag)
      , .w_v_i(btb_w_v)
      , .idx_w_i(cmd_i.metadata.btb_indx)
      , .tag_w_i(cmd_i.metadata.btb_tag)
      , .target_i(cmd_i.target_pc)
      , .target_o(pred_target_o)
      , .hit_o(btb_hit)
      );

   // a taken counter without a BTB hit has no target to go to
   assign pred_taken_o    = bht_predict && btb_hit;
   assign pred_metadata_o = lookup_md_q;

endmodule

/* rtl/bp_fe_btb.sv */
`timescale 1ns/1ps

// direct-mapped branch target buffer with tags
module bp_fe_btb
  (input  logic                                     clk_i
   , input  logic                                   rst_n_i

   , input  logic                                   r_v_i
   , input  logic [bp_fe_cfg_pkg::btb_indx_width-1:0] idx_r_i
   , input  logic [bp_fe_cfg_pkg::btb_tag_width-1:0]  tag_r_i

   , input  logic                                   w_v_i
   , input  logic [bp_fe_cfg_pkg::btb_indx_width-1:0] idx_w_i
   , input  logic [bp_fe_cfg_pkg::btb_tag_width-1:0]  tag_w_i
   , input  logic [bp_fe_cfg_pkg::eaddr_width-1:0]    target_i

   , output logic [bp_fe_cfg_pkg::eaddr_width-1:0]    target_o
   , output logic                                   hit_o
   );

   localparam int btb_entries = 1 << bp_fe_cfg_pkg::btb_indx_width;

   logic                                    valid_q  [btb_entries];
   logic [bp_fe_cfg_pkg::btb_tag_width-1:0] tag_q    [btb_entries];
   logic [bp_fe_cfg_pkg::eaddr_width-1:0]   target_q [btb_entries];

   logic                                    hit_q;
   logic [bp_fe_cfg_pkg::eaddr_width-1:0]   target_r_q;

   // an entry turns valid on its first write and stays valid
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < btb_entries; i++) begin
            valid_q[i] <= 1'b0;
         end
      end else if (w_v_i) begin
         valid_q[idx_w_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_v_i) begin
         tag_q[idx_w_i]    <= tag_w_i;
         target_q[idx_w_i] <= target_i;
      end
   end

   // hit needs both a valid entry and a matching tag
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_q <= 1'b0;
      end else if (r_v_i) begin
         hit_q <= valid_q[idx_r_i] && (tag_q[idx_r_i] == tag_r_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_v_i) begin
         target_r_q <= target_q[idx_r_i];
      end
   end

   assign hit_o    = hit_q;
   assign target_o = target_r_q;

   // the fetch PC steps by words so a stored target must be word aligned
   a_target_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_v_i |-> (target_i[1:0] == 2'b00));

endmodule

/* rtl/bp_fe_cfg_pkg.sv */
// widths and constants shared by every block of the fetch front end
package bp_fe_cfg_pkg;

   // every PC in the front end has this width
   localparam int eaddr_width = 32;

   // 16 BTB entries and 64 BHT counters
   localparam int btb_indx_width = 4;
   localparam int bht_indx_width = 6;

   // the tag is the part of the PC above the BTB index and the byte offset
   localparam int btb_tag_width = eaddr_width - btb_indx_width - 2;

   // fetch starts here after reset
   localparam logic [eaddr_width-1:0] reset_pc = 32'h0000_1000;

   // 2-bit saturating direction counter
   // the two upper states predict taken
   typedef enum logic [1:0] {
      e_strong_nt = 2'b00
      , e_weak_nt = 2'b01
      , e_weak_t  = 2'b10
      , e_strong_t = 2'b11
   } bp_fe_ctr_e;

endpackage

/* rtl/bp_fe_pc_gen.sv */
`timescale 1ns/1ps

// two-stage fetch PC generator
module bp_fe_pc_gen
  (input  logic                                  clk_i
   , input  logic                                rst_n_i

   , input  logic                                fetch_ready_i
   , input  bp_fe_pkg::bp_fe_cmd_s               cmd_i

   , input  logic                                pred_taken_i
   , input  logic [bp_fe_cfg_pkg::eaddr_width-1:0] pred_target_i
   , input  bp_fe_pkg::bp_fe_branch_metadata_s   pred_metadata_i

   , output logic                                lookup_v_o
   , output logic [bp_fe_cfg_pkg::eaddr_width-1:0] lookup_pc_o
   , output bp_fe_pkg::bp_fe_fetch_s             fetch_o
   );

   logic [bp_fe_cfg_pkg::eaddr_width-1:0] pc_f1_q;
   logic [bp_fe_cfg_pkg::eaddr_width-1:0] pc_f1_n;
   logic                                  f2_v_q;
   logic                                  f2_v_n;
   logic [bp_fe_cfg_pkg::eaddr_width-1:0] f2_pc_q;

   logic redirect;
   logic advance;
   logic accept;

   assign redirect = cmd_i.v && ((cmd_i.op == bp_fe_pkg::e_op_mispredict)
                                 || (cmd_i.op == bp_fe_pkg::e_op_redirect));

   // stage 1 moves on when stage 2 is empty or leaving
   assign advance = !f2_v_q || fetch_ready_i;
   assign accept  = f2_v_q && fetch_ready_i;

   always_comb begin
      pc_f1_n = pc_f1_q;
      f2_v_n  = f2_v_q;
      if (redirect) begin
         pc_f1_n = cmd_i.target_pc;
         f2_v_n  = 1'b0;
      end else if (accept && pred_taken_i) begin
         // the PC now leaving stage 1 is on the wrong path
         pc_f1_n = pred_target_i;
         f2_v_n  = 1'b0;
      end else if (advance) begin
         pc_f1_n = pc_f1_q + bp_fe_cfg_pkg::eaddr_width'(4);
         f2_v_n  = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_f1_q <= bp_fe_cfg_pkg::reset_pc;
         f2_v_q  <= 1'b0;
      end else begin
         pc_f1_q <= pc_f1_n;
         f2_v_q  <= f2_v_n;
      end
   end

   always_ff @(posedge clk_i) begin
      if (advance) begin
         f2_pc_q <= pc_f1_q;
      end
   end

   assign lookup_v_o  = advance;
   assign lookup_pc_o = pc_f1_q;

   // prediction outputs hold while no lookup is issued
   assign fetch_o.v             = f2_v_q;
   assign fetch_o.pc            = f2_pc_q;
   assign fetch_o.predict_taken = pred_taken_i;
   assign fetch_o.metadata      = pred_metadata_i;

   a_fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fetch_o.v && !fetch_ready_i && !redirect) |=> $stable(fetch_o));

endmodule

/* rtl/bp_fe_pkg.sv */
// types exchanged between the front end and the back end
package bp_fe_pkg;

   // metadata travels with each fetch and comes back with a command
   // both indices start at pc bit 2
   typedef struct packed {
      logic [bp_fe_cfg_pkg::btb_indx_width-1:0] btb_indx;
      logic [bp_fe_cfg_pkg::btb_tag_width-1:0]  btb_tag;
      logic [bp_fe_cfg_pkg::bht_indx_width-1:0] bht_indx;
   } bp_fe_branch_metadata_s;

   // back-end command opcodes
   typedef enum logic [1:0] {
      e_op_none
      , e_op_attaboy
      , e_op_mispredict
      , e_op_redirect
   } bp_fe_cmd_op_e;

   // target_pc always holds the correct next PC of the branch
   typedef struct packed {
      logic                                  v;
      bp_fe_cmd_op_e                         op;
      logic                                  taken;
      logic [bp_fe_cfg_pkg::eaddr_width-1:0] target_pc;
      bp_fe_branch_metadata_s                metadata;
   } bp_fe_cmd_s;

   // one fetched PC with its prediction
   typedef struct packed {
      logic                                  v;
      logic [bp_fe_cfg_pkg::eaddr_width-1:0] pc;
      logic                                  predict_taken;
      bp_fe_branch_metadata_s                metadata;
   } bp_fe_fetch_s;

endpackage

/* rtl/bp_fe_top.sv */
`timescale 1ns/1ps

// fetch front end with branch prediction
module bp_fe_top
  (input  logic                      clk_i
   , input  logic                    rst_n_i

   , input  bp_fe_pkg::bp_fe_cmd_s   cmd_i
   , input  logic                    fetch_ready_i
   , output bp_fe_pkg::bp_fe_fetch_s fetch_o
   );

   logic                                  lookup_v;
   logic [bp_fe_cfg_pkg::eaddr_width-1:0] lookup_pc;
   logic                                  pred_taken;
   logic [bp_fe_cfg_pkg::eaddr_width-1:0] pred_target;
   bp_fe_pkg::bp_fe_branch_metadata_s     pred_metadata;

   bp_fe_pc_gen pc_gen_i
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .fetch_ready_i(fetch_ready_i)
      , .cmd_i(cmd_i)
      , .pred_taken_i(pred_taken)
      , .pred_target_i(pred_target)
      , .pred_metadata_i(pred_metadata)
      , .lookup_v_o(lookup_v)
      , .lookup_pc_o(lookup_pc)
      , .fetch_o(fetch_o)
      );

   // the predictor trains from the same commands that redirect fetch
   bp_fe_branch_predictor bp_i
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .lookup_v_i(lookup_v)
      , .lookup_pc_i(lookup_pc)
      , .cmd_i(cmd_i)
      , .pred_taken_o(pred_taken)
      , .pred_target_o(pred_target)
      , .pred_metadata_o(pred_metadata)
      );

endmodule

/* src.f */
rtl/bp_fe_cfg_pkg.sv
rtl/bp_fe_pkg.sv
rtl/bp_fe_bht.sv
rtl/bp_fe_btb.sv
rtl/bp_fe_branch_predictor.sv
rtl/bp_fe_pc_gen.sv
rtl/bp_fe_top.sv
verification/bp_fe_tb.sv

/* verification/bp_fe_tb.sv */
`timescale 1ns/1ps

module bp_fe_tb;

   localparam int aw      = bp_fe_cfg_pkg::eaddr_width;
   localparam int n_steps = 12;

   // one row of the stimulus table
   typedef struct packed {
      bp_fe_pkg::bp_fe_cmd_op_e op;
      logic                     taken;
      logic [aw-1:0]            target_pc;
      logic [aw-1:0]            md_pc;
      logic                     rand_ready;
      logic [7:0]               n_fetch;
   } step_s;

   logic                    clk;
   logic                    rst_n;
   bp_fe_pkg::bp_fe_cmd_s   cmd;
   logic                    fetch_ready;
   bp_fe_pkg::bp_fe_fetch_s fetch;

   step_s steps [n_steps];

   // reference copy of the prediction tables
   bp_fe_cfg_pkg::bp_fe_ctr_e               ctr_m     [1 << bp_fe_cfg_pkg::bht_indx_width];
   logic                                    btb_v_m   [1 << bp_fe_cfg_pkg::btb_indx_width];
   logic [bp_fe_cfg_pkg::btb_tag_width-1:0] btb_tag_m [1 << bp_fe_cfg_pkg::btb_indx_width];
   logic [aw-1:0]                           btb_tgt_m [1 << bp_fe_cfg_pkg::btb_indx_width];

   logic [31:0] lcg_state;
   int          errors;
   int          cycles = 0;
   int          cycle_limit = 100;

   bp_fe_top dut_i
     (.clk_i(clk)
      , .rst_n_i(rst_n)
      , .cmd_i(cmd)
      , .fetch_ready_i(fetch_ready)
      , .fetch_o(fetch)
      );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: the expected fetches did not arrive within %0d cycles", cycle_limit);
         $display("errors: %0d", errors);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // indices start at pc bit 2 and the tag is everything above the BTB index
   function automatic bp_fe_pkg::bp_fe_branch_metadata_s md_of(input logic [aw-1:0] pc);
      bp_fe_pkg::bp_fe_branch_metadata_s md;
      md.btb_indx = pc[2 +: bp_fe_cfg_pkg::btb_indx_width];
      md.btb_tag  = pc[aw-1 -: bp_fe_cfg_pkg::btb_tag_width];
      md.bht_indx = pc[2 +: bp_fe_cfg_pkg::bht_indx_width];
      return md;
   endfunction

   function automatic logic model_predict(input logic [aw-1:0] pc);
      bp_fe_pkg::bp_fe_branch_metadata_s md;
      logic                              dir;
      md  = md_of(pc);
      dir = (ctr_m[md.bht_indx] == bp_fe_cfg_pkg::e_weak_t)
            || (ctr_m[md.bht_indx] == bp_fe_cfg_pkg::e_strong_t);
      return dir && btb_v_m[md.btb_indx] && (btb_tag_m[md.btb_indx] == md.btb_tag);
   endfunction

   task automatic train_model(input step_s st);
      bp_fe_pkg::bp_fe_branch_metadata_s md;
      bp_fe_cfg_pkg::bp_fe_ctr_e         c;
      md = md_of(st.md_pc);
      if ((st.op == bp_fe_pkg::e_op_attaboy) || (st.op == bp_fe_pkg::e_op_mispredict)) begin
         c = ctr_m[md.bht_indx];
         if (st.taken && (c != bp_fe_cfg_pkg::e_strong_t)) begin
            c = bp_fe_cfg_pkg::bp_fe_ctr_e'(c + 2'd1);
         end else if (!st.taken && (c != bp_fe_cfg_pkg::e_strong_nt)) begin
            c = bp_fe_cfg_pkg::bp_fe_ctr_e'(c - 2'd1);
         end
         ctr_m[md.bht_indx] = c;
      end
      if ((st.op == bp_fe_pkg::e_op_mispredict) && st.taken) begin
         btb_v_m[md.btb_indx]   = 1'b1;
         btb_tag_m[md.btb_indx] = md.btb_tag;
         btb_tgt_m[md.btb_indx] = st.target_pc;
      end
   endtask

   task automatic set_step(input int i, input bp_fe_pkg::bp_fe_cmd_op_e op, input logic taken,
                           input logic [aw-1:0] target_pc, input logic [aw-1:0] md_pc,
                           input logic rand_ready, input int n_fetch);
      steps[i] = '{op, taken, target_pc, md_pc, rand_ready, 8'(n_fetch)};
   endtask

   task automatic fill_steps();
      set_step(0, bp_fe_pkg::e_op_none, 1'b0, 32'h0, 32'h0, 1'b0, 4);
      // a taken branch at 0x1008 goes to 0x2000
      set_step(1, bp_fe_pkg::e_op_mispredict, 1'b1, 32'h2000, 32'h1008, 1'b0, 4);
      // a redirect with taken set must still leave both tables alone
      set_step(2, bp_fe_pkg::e_op_redirect, 1'b1, 32'h1000, 32'h1000, 1'b0, 5);
      set_step(3, bp_fe_pkg::e_op_attaboy, 1'b1, 32'h2000, 32'h1008, 1'b0, 0);
      set_step(4, bp_fe_pkg::e_op_mispredict, 1'b0, 32'h100c, 32'h1008, 1'b0, 2);
      set_step(5, bp_fe_pkg::e_op_redirect, 1'b0, 32'h1004, 32'h1004, 1'b0, 3);
      set_step(6, bp_fe_pkg::e_op_mispredict, 1'b0, 32'h100c, 32'h1008, 1'b0, 1);
      set_step(7, bp_fe_pkg::e_op_redirect, 1'b0, 32'h1004, 32'h1004, 1'b1, 4);
      set_step(8, bp_fe_pkg::e_op_redirect, 1'b0, 32'h3000, 32'h3000, 1'b1, 6);
      // 0x5008 shares the BTB index and the counter of 0x1008 but not the tag
      set_step(9, bp_fe_pkg::e_op_attaboy, 1'b1, 32'h6000, 32'h5008, 1'b0, 0);
      set_step(10, bp_fe_pkg::e_op_redirect, 1'b0, 32'h5000, 32'h5000, 1'b1, 4);
      set_step(11, bp_fe_pkg::e_op_redirect, 1'b0, 32'h1004, 32'h1004, 1'b1, 3);
   endtask

   initial begin
      int                                accepted;
      logic [aw-1:0]                     exp_pc;
      logic                              exp_pt;
      bp_fe_pkg::bp_fe_branch_metadata_s exp_md;
      logic                              held;
      bp_fe_pkg::bp_fe_fetch_s           held_fetch;
      clk         = 1'b0;
      rst_n       = 1'b0;
      fetch_ready = 1'b0;
      cmd         = '0;
      errors      = 0;
      lcg_state   = 32'h5676;
      held        = 1'b0;
      held_fetch  = '0;
      fill_steps();
      for (int i = 0; i < n_steps; i++) begin
         cycle_limit += 8 * steps[i].n_fetch;
      end
      foreach (ctr_m[i]) begin
         ctr_m[i] = bp_fe_cfg_pkg::e_weak_nt;
      end
      foreach (btb_v_m[i]) begin
         btb_v_m[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n  = 1'b1;
      exp_pc = bp_fe_cfg_pkg::reset_pc;
      for (int s = 0; s < n_steps; s++) begin
         if (steps[s].op != bp_fe_pkg::e_op_none) begin
            cmd.v         = 1'b1;
            cmd.op        = steps[s].op;
            cmd.taken     = steps[s].taken;
            cmd.target_pc = steps[s].target_pc;
            cmd.metadata  = md_of(steps[s].md_pc);
            fetch_ready   = 1'b0;
            @(negedge clk);
            cmd = '0;
            train_model(steps[s]);
            if (steps[s].op != bp_fe_pkg::e_op_attaboy) begin
               exp_pc = steps[s].target_pc;
            end
            held = 1'b0;
         end
         accepted = 0;
         while (accepted < steps[s].n_fetch) begin
            // an offered fetch that was refused must still be offered unchanged
            if (held && !fetch.v) begin
               $display("error at %0t: fetch_o.v dropped before the fetch was accepted", $time);
               errors++;
            end
            if (held && (fetch.pc !== held_fetch.pc)) begin
               $display("error at %0t: fetch_o.pc expected %h actual %h",
                        $time, held_fetch.pc, fetch.pc);
               errors++;
            end
            if (held && (fetch.predict_taken !== held_fetch.predict_taken)) begin
               $display("error at %0t: fetch_o.predict_taken expected %b actual %b",
                        $time, held_fetch.predict_taken, fetch.predict_taken);
               errors++;
            end
            if (steps[s].rand_ready) begin
               lcg_state   = lcg_next(lcg_state);
               fetch_ready = lcg_state[16];
            end else begin
               fetch_ready = 1'b1;
            end
            held       = fetch.v && !fetch_ready;
            held_fetch = fetch;
            if (fetch.v && fetch_ready) begin
               exp_pt = model_predict(exp_pc);
               exp_md = md_of(exp_pc);
               if (fetch.pc !== exp_pc) begin
                  $display("error at %0t: fetch_o.pc expected %h actual %h",
                           $time, exp_pc, fetch.pc);
                  errors++;
               end
               if (fetch.predict_taken !== exp_pt) begin
                  $display("error at %0t: fetch_o.predict_taken expected %b actual %b",
                           $time, exp_pt, fetch.predict_taken);
                  errors++;
               end
               if (fetch.metadata !== exp_md) begin
                  $display("error at %0t: fetch_o.metadata expected %h actual %h",
                           $time, exp_md, fetch.metadata);
                  errors++;
               end
               exp_pc = exp_pt ? btb_tgt_m[exp_md.btb_indx] : exp_pc + 32'd4;
               accepted++;
            end
            @(negedge clk);
         end
      end
      fetch_ready = 1'b0;
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
